//--- logic/array_defines.svh
// build defines: channel count, component width, magnitude pipeline depth

`ifndef ARRAY_DEFINES_SVH
`define ARRAY_DEFINES_SVH

////////////////////
// array geometry
////////////////////

// antenna channels per input beat
`define NUM_CHANNELS 4

// bits in one I or Q component, two's complement
`define IQ_WIDTH 16

////////////////////
// magnitude unit
////////////////////

// enabled cycles through iq_magnitude
// must track the register stages in that module
`define MAG_DELAY 2

`endif

//--- logic/array_pkg.sv
// array package: channel index width, I/Q sample, vectors, frame structs, output state

`include "array_defines.svh"

package array_pkg;

  // width of a channel index, at least one bit
  localparam int CH_IDX_W = (`NUM_CHANNELS > 1) ? $clog2(`NUM_CHANNELS) : 1;

  ////////////////////
  // sample types
  ////////////////////

  typedef struct packed {
    logic signed [`IQ_WIDTH-1:0] re;
    logic signed [`IQ_WIDTH-1:0] im;
  } iq_sample_t;

  typedef iq_sample_t [`NUM_CHANNELS-1:0] channel_vec_t;

  // one extra bit so max + 3/8 min never wraps
  typedef logic [`IQ_WIDTH:0] mag_t;

  typedef mag_t [`NUM_CHANNELS-1:0] mag_vec_t;

  ////////////////////
  // frame types
  ////////////////////

  // serializer to peak selector
  typedef struct packed {
    channel_vec_t samples;
    mag_vec_t     mags;
  } mag_frame_t;

  typedef struct packed {
    channel_vec_t          samples;
    mag_vec_t              mags;
    logic [CH_IDX_W-1:0]   peak_index;
    mag_t                  peak_mag;
  } peak_frame_t;

  // registered output stage
  typedef enum logic {
    OUT_EMPTY,
    OUT_FULL
  } out_state_t;

endpackage

//--- logic/stage_delay.sv
// enable-gated shift register with configurable width and depth

module stage_delay #(
  parameter int WIDTH = 1,
  parameter int DEPTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  // taps[0] takes din, taps[DEPTH-1] is the output
  logic [WIDTH-1:0] taps [DEPTH];

  ////////////////////
  // shift chain
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else if (ena) begin
      taps[0] <= din;
      // older entries move one place along
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign dout = taps[DEPTH-1];

endmodule

//--- logic/iq_magnitude.sv
// two-stage alpha-max-plus-beta-min magnitude of one complex sample

`include "array_defines.svh"

module iq_magnitude
  import array_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ena,
  input  iq_sample_t sample,
  output mag_t       mag
);

  localparam int W = `IQ_WIDTH;

  // stage one results
  logic [W-1:0] abs_re;
  logic [W-1:0] abs_im;

  // ordered operands for stage two
  logic [W-1:0] big;
  logic [W-1:0] little;

  // |x| with the most negative code pinned to the largest positive
  function automatic logic [W-1:0] sat_abs(input logic signed [W-1:0] x);
    logic [W-1:0] most_neg;
    logic [W-1:0] most_pos;
    most_neg = {1'b1, {(W-1){1'b0}}};
    most_pos = {1'b0, {(W-1){1'b1}}};
    if (x == most_neg) begin
      return most_pos;
    end else if (x[W-1]) begin
      return -x;
    end else begin
      return x;
    end
  endfunction

  ////////////////////
  // stage one
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      abs_re <= '0;
      abs_im <= '0;
    end else if (ena) begin
      abs_re <= sat_abs(sample.re);
      abs_im <= sat_abs(sample.im);
    end
  end

  ////////////////////
  // stage two
  ////////////////////

  assign big    = (abs_re >= abs_im) ? abs_re : abs_im;
  assign little = (abs_re >= abs_im) ? abs_im : abs_re;

  // max + min/4 + min/8
  always_ff @(posedge clk) begin
    if (rst) begin
      mag <= '0;
    end else if (ena) begin
      mag <= mag_t'(big) + mag_t'(little >> 2) + mag_t'(little >> 3);
    end
  end

endmodule

//--- logic/magnitude_serializer.sv
// channel serializer: counter, shared magnitude unit, result store, alignment, output register

`include "array_defines.svh"

module magnitude_serializer
  import array_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         in_valid,
  output logic         in_ready,
  input  channel_vec_t in_data,
  output logic         mid_valid,
  input  logic         mid_ready,
  output mag_frame_t   mid_data
);

  localparam logic [CH_IDX_W-1:0] LAST_CH = CH_IDX_W'(`NUM_CHANNELS - 1);

  // channel counter
  logic [CH_IDX_W-1:0] count;
  logic                last_ch;
  logic                in_fire;
  logic                cnt_ena;

  // pipeline control
  logic                stall;
  logic                pipe_ena;

  // magnitude unit
  iq_sample_t          cur_sample;
  mag_t                cur_mag;

  // aligned with cur_mag
  logic [CH_IDX_W-1:0] idx_d;
  logic [1:0]          tag_in;
  logic [1:0]          tag_d;
  logic                tag_valid;
  logic                tag_last;

  // result store and frame completion
  mag_vec_t            mag_store;
  logic                frame_done;
  channel_vec_t        samples_d;

  // output register
  out_state_t          mid_state;

  ////////////////////
  // input side
  ////////////////////

  // a frame is complete and the output register cannot take it
  assign stall    = frame_done && (mid_state == OUT_FULL) && !mid_ready;
  assign pipe_ena = !stall;

  assign last_ch  = (count == LAST_CH);
  assign in_ready = last_ch && !stall;
  assign in_fire  = in_valid && in_ready;
  assign cnt_ena  = in_valid && !stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (in_fire) begin
      count <= '0;
    end else if (cnt_ena) begin
      count <= count + 1'b1;
    end
  end

  ////////////////////
  // magnitude pipeline
  ////////////////////

  assign cur_sample = in_data[count];

  iq_magnitude u_mag (
    .clk    (clk),
    .rst    (rst),
    .ena    (pipe_ena),
    .sample (cur_sample),
    .mag    (cur_mag)
  );

  // channel index follows its sample through the unit
  stage_delay #(
    .WIDTH (CH_IDX_W),
    .DEPTH (`MAG_DELAY)
  ) u_idx_delay (
    .clk  (clk),
    .rst  (1'b0),
    .ena  (pipe_ena),
    .din  (count),
    .dout (idx_d)
  );

  // bubble when in_valid is low
  assign tag_in = {in_valid, last_ch};

  stage_delay #(
    .WIDTH (2),
    .DEPTH (`MAG_DELAY)
  ) u_tag_delay (
    .clk  (clk),
    .rst  (rst),
    .ena  (pipe_ena),
    .din  (tag_in),
    .dout (tag_d)
  );

  assign tag_valid = tag_d[1];
  assign tag_last  = tag_d[0];

  ////////////////////
  // result store
  ////////////////////

  always_ff @(posedge clk) begin
    if (pipe_ena && tag_valid) begin
      mag_store[idx_d] <= cur_mag;
    end
  end

  // set once the last channel has been written
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_done <= 1'b0;
    end else if (pipe_ena) begin
      frame_done <= tag_valid && tag_last;
    end
  end

  // samples held one stage longer, to line up with frame_done
  stage_delay #(
    .WIDTH ($bits(channel_vec_t)),
    .DEPTH (`MAG_DELAY + 1)
  ) u_data_delay (
    .clk  (clk),
    .rst  (1'b0),
    .ena  (pipe_ena),
    .din  (in_data),
    .dout (samples_d)
  );

  ////////////////////
  // output register
  ////////////////////

  assign mid_valid = (mid_state == OUT_FULL);

  always_ff @(posedge clk) begin
    if (rst) begin
      mid_state <= OUT_EMPTY;
    end else if (frame_done && !stall) begin
      mid_state <= OUT_FULL;
    end else if (mid_valid && mid_ready) begin
      mid_state <= OUT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_done && !stall) begin
      mid_data.samples <= samples_d;
      mid_data.mags    <= mag_store;
    end
  end

endmodule

//--- logic/peak_channel_select.sv
// peak selector: comparison tree over channel magnitudes and one-entry output register

`include "array_defines.svh"

module peak_channel_select
  import array_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        mid_valid,
  output logic        mid_ready,
  input  mag_frame_t  mid_data,
  output logic        out_valid,
  input  logic        out_ready,
  output peak_frame_t out_data
);

  // leaves padded up to a power of two
  localparam int LEAVES = 1 << CH_IDX_W;
  localparam int NODES  = 2 * LEAVES - 1;

  mag_t [LEAVES-1:0]   leaf_mag;
  mag_t                node_mag [NODES];
  logic [CH_IDX_W-1:0] node_idx [NODES];
  out_state_t          out_state;

  ////////////////////
  // comparison tree
  ////////////////////

  // padding leaves sit above every real channel, so they never win a tie
  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < `NUM_CHANNELS) begin : g_real
      assign leaf_mag[i] = mid_data.mags[i];
    end else begin : g_pad
      assign leaf_mag[i] = '0;
    end
  end

  // heap layout, node n has children 2n+1 and 2n+2
  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      node_mag[LEAVES-1+i] = leaf_mag[i];
      node_idx[LEAVES-1+i] = CH_IDX_W'(i);
    end
    for (int n = LEAVES - 2; n >= 0; n--) begin
      // left child holds lower indices and wins on equal
      if (node_mag[2*n+2] > node_mag[2*n+1]) begin
        node_mag[n] = node_mag[2*n+2];
        node_idx[n] = node_idx[2*n+2];
      end else begin
        node_mag[n] = node_mag[2*n+1];
        node_idx[n] = node_idx[2*n+1];
      end
    end
  end

  ////////////////////
  // output stage
  ////////////////////

  assign out_valid = (out_state == OUT_FULL);
  assign mid_ready = (out_state == OUT_EMPTY) || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_state <= OUT_EMPTY;
    end else if (mid_valid && mid_ready) begin
      out_state <= OUT_FULL;
    end else if (out_valid && out_ready) begin
      out_state <= OUT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (mid_valid && mid_ready) begin
      out_data.samples    <= mid_data.samples;
      out_data.mags       <= mid_data.mags;
      out_data.peak_index <= node_idx[0];
      out_data.peak_mag   <= node_mag[0];
    end
  end

endmodule

//--- logic/array_magnitude_top.sv
// top level: magnitude serializer feeding the peak channel selector

module array_magnitude_top
  import array_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         in_valid,
  output logic         in_ready,
  input  channel_vec_t in_data,
  output logic         out_valid,
  input  logic         out_ready,
  output peak_frame_t  out_data
);

  // serializer to selector link
  logic       mid_valid;
  logic       mid_ready;
  mag_frame_t mid_data;

  ////////////////////
  // magnitudes
  ////////////////////

  magnitude_serializer u_serializer (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready),
    .mid_data  (mid_data)
  );

  ////////////////////
  // peak search
  ////////////////////

  peak_channel_select u_peak (
    .clk       (clk),
    .rst       (rst),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready),
    .mid_data  (mid_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

//--- tests/array_magnitude_tb.sv
// testbench: clock, reset, corner and random frames, reference model, back-pressure, checks, watchdog

`include "array_defines.svh"

module array_magnitude_tb
  import array_pkg::*;
();

  localparam int NCH           = `NUM_CHANNELS;
  localparam int W             = `IQ_WIDTH;
  localparam int LATENCY       = `MAG_DELAY + 3;
  localparam int RANDOM_FRAMES = 200;
  localparam int WATCHDOG_TIME = RANDOM_FRAMES * (NCH + 10) * 2 * 4;
  localparam int MAX_POS       = (1 << (W - 1)) - 1;
  localparam int MIN_NEG       = -(1 << (W - 1));

  logic         clk = 1'b0;
  logic         rst;
  logic         in_valid;
  logic         in_ready;
  channel_vec_t in_data;
  logic         out_valid;
  logic         out_ready;
  peak_frame_t  out_data;

  // test control
  string        test_name = "reset";
  logic         lat_mode  = 1'b0;
  logic         bp_enable = 1'b0;
  logic         lat_fire;

  // scoreboard
  peak_frame_t  exp_q [$];
  string        name_q [$];
  int           frames_in       = 0;
  int           frames_out      = 0;
  int           value_errors    = 0;
  int           protocol_errors = 0;

  always #2 clk = ~clk;

  array_magnitude_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  ////////////////////
  // reference model
  ////////////////////

  function automatic int abs_sat(input logic signed [W-1:0] v);
    int x;
    x = int'(v);
    if (x < 0) begin
      x = -x;
    end
    // most negative code has no positive twin
    if (x > MAX_POS) begin
      x = MAX_POS;
    end
    return x;
  endfunction

  function automatic mag_t expected_mag(input iq_sample_t s);
    int a;
    int b;
    int hi;
    int lo;
    a  = abs_sat(s.re);
    b  = abs_sat(s.im);
    hi = (a > b) ? a : b;
    lo = (a > b) ? b : a;
    return mag_t'(hi + lo / 4 + lo / 8);
  endfunction

  function automatic peak_frame_t expected_frame(input channel_vec_t f);
    peak_frame_t e;
    int          best;
    e.samples = f;
    best = 0;
    for (int i = 0; i < NCH; i++) begin
      e.mags[i] = expected_mag(f[i]);
    end
    // strict compare keeps the lowest index on ties
    for (int i = 1; i < NCH; i++) begin
      if (e.mags[i] > e.mags[best]) begin
        best = i;
      end
    end
    e.peak_index = CH_IDX_W'(best);
    e.peak_mag   = e.mags[best];
    return e;
  endfunction

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic iq_sample_t make_sample(input int re, input int im);
    iq_sample_t s;
    s.re = W'(re);
    s.im = W'(im);
    return s;
  endfunction

  function automatic channel_vec_t fill_frame(input int re, input int im);
    channel_vec_t f;
    for (int i = 0; i < NCH; i++) begin
      f[i] = make_sample(re, im);
    end
    return f;
  endfunction

  // extremes show up often enough to matter
  function automatic logic [W-1:0] random_component();
    int sel;
    sel = int'($urandom_range(0, 15));
    case (sel)
      0:       return W'(MAX_POS);
      1:       return W'(MIN_NEG);
      2:       return '0;
      default: return W'($urandom);
    endcase
  endfunction

  function automatic channel_vec_t random_frame();
    channel_vec_t f;
    for (int i = 0; i < NCH; i++) begin
      f[i].re = random_component();
      f[i].im = random_component();
    end
    // occasional tie with channel 0
    if ($urandom_range(0, 7) == 0) begin
      f[NCH-1] = f[0];
    end
    return f;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // holds valid and data until the beat is taken
  task automatic send_frame(input channel_vec_t f);
    logic done;
    in_data  = f;
    in_valid = 1'b1;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = in_valid && in_ready;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    in_data  = random_frame();
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_isolated(input channel_vec_t f);
    send_frame(f);
    wait_drained();
    idle_cycles(2);
  endtask

  task automatic corner_sequence();
    channel_vec_t f;
    send_isolated(fill_frame(0, 0));
    send_isolated(fill_frame(MAX_POS, MAX_POS));
    send_isolated(fill_frame(MIN_NEG, MIN_NEG));
    send_isolated(fill_frame(MIN_NEG, MAX_POS));
    // mixed signs
    for (int i = 0; i < NCH; i++) begin
      case (i % 4)
        0:       f[i] = make_sample(MAX_POS, MIN_NEG);
        1:       f[i] = make_sample(-1, 1);
        2:       f[i] = make_sample(MIN_NEG, 0);
        default: f[i] = make_sample(100, -200);
      endcase
    end
    send_isolated(f);
    // peak in the last channel
    f = fill_frame(10, -10);
    f[NCH-1] = make_sample(-3000, 2000);
    send_isolated(f);
    // equal peaks at channel 1 and the last channel
    f = fill_frame(5, 5);
    f[1 % NCH] = make_sample(MIN_NEG, MAX_POS);
    f[NCH-1]   = make_sample(MAX_POS, MIN_NEG);
    send_isolated(f);
    for (int i = 0; i < NCH; i++) begin
      f[i] = (i % 2 == 0) ? make_sample(1000, -400) : make_sample(-400, 1000);
    end
    send_isolated(f);
    for (int i = 0; i < NCH; i++) begin
      f[i] = make_sample(-(2 * i + 1), 3 * i);
    end
    send_isolated(f);
  endtask

  task automatic random_sequence();
    for (int n = 0; n < RANDOM_FRAMES; n++) begin
      send_frame(random_frame());
      idle_cycles(int'($urandom_range(0, 5)));
    end
  endtask

  ////////////////////
  // checking
  ////////////////////

  task automatic report_value(input string name, input string field,
                              input string exp_s, input string act_s);
    value_errors++;
    $display("[FAIL] %s frame %0d %s: expected %s actual %s",
             name, frames_out, field, exp_s, act_s);
  endtask

  task automatic check_output(input peak_frame_t got);
    peak_frame_t exp;
    string       name;
    if (exp_q.size() == 0) begin
      protocol_errors++;
      $display("output frame %0d arrived with no input frame outstanding", frames_out);
    end else begin
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      assert (got.samples == exp.samples) else begin
        report_value(name, "samples", $sformatf("%h", exp.samples),
                     $sformatf("%h", got.samples));
      end
      for (int i = 0; i < NCH; i++) begin
        assert (got.mags[i] == exp.mags[i]) else begin
          report_value(name, $sformatf("mag[%0d]", i), $sformatf("%0d", exp.mags[i]),
                       $sformatf("%0d", got.mags[i]));
        end
      end
      assert (got.peak_index == exp.peak_index) else begin
        report_value(name, "peak_index", $sformatf("%0d", exp.peak_index),
                     $sformatf("%0d", got.peak_index));
      end
      assert (got.peak_mag == exp.peak_mag) else begin
        report_value(name, "peak_mag", $sformatf("%0d", exp.peak_mag),
                     $sformatf("%0d", got.peak_mag));
      end
    end
    frames_out++;
  endtask

  // handshakes sampled mid-cycle, where both sides have settled
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(expected_frame(in_data));
      name_q.push_back(test_name);
      frames_in++;
    end
    if (!rst && out_valid && out_ready) begin
      check_output(out_data);
    end
  end

  assign lat_fire = in_valid && in_ready && lat_mode;

  reset_check: assert property (@(posedge clk) $fell(rst) |-> (!out_valid && !in_ready))
  else begin
    protocol_errors++;
    $display("out_valid or in_ready high in the first cycle after reset");
  end

  hold_check: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
  else begin
    protocol_errors++;
    $display("output changed while out_ready was low");
  end

  beat_check: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready) |=> !in_ready)
  else begin
    protocol_errors++;
    $display("in_ready high on two consecutive cycles");
  end

  latency_check: assert property (@(posedge clk) disable iff (rst)
    $past(lat_fire, LATENCY) |-> (out_valid && !$past(out_valid)))
  else begin
    protocol_errors++;
    $display("out_valid did not rise exactly %0d cycles after the input transfer", LATENCY);
  end

  ////////////////////
  // run control
  ////////////////////

  task automatic print_summary();
    $display("errors: %0d value, %0d protocol; frames in %0d, out %0d",
             value_errors, protocol_errors, frames_in, frames_out);
  endtask

  // random back-pressure in stretches
  initial begin : ready_driver
    int   stretch;
    logic level;
    out_ready = 1'b1;
    stretch   = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!bp_enable) begin
        out_ready = 1'b1;
      end else if (stretch > 0) begin
        stretch--;
      end else begin
        level     = ($urandom_range(0, 7) < 5);
        stretch   = int'($urandom_range(0, level ? 3 : 11));
        out_ready = level;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units with %0d frames outstanding",
             WATCHDOG_TIME, exp_q.size());
    print_summary();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(32'hb33e33ee));
    rst      = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_cycles(3);
    // isolated frames with out_ready high, latency checked on each
    test_name = "corner";
    lat_mode  = 1'b1;
    corner_sequence();
    lat_mode  = 1'b0;
    test_name = "random";
    bp_enable = 1'b1;
    random_sequence();
    bp_enable = 1'b0;
    wait_drained();
    idle_cycles(LATENCY + 2);
    assert (frames_out == frames_in) else begin
      protocol_errors++;
      $display("%0d frames sent but %0d frames received", frames_in, frames_out);
    end
    print_summary();
    if (value_errors + protocol_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/array_pkg.sv
logic/stage_delay.sv
logic/iq_magnitude.sv
logic/magnitude_serializer.sv
logic/peak_channel_select.sv
logic/array_magnitude_top.sv
tests/array_magnitude_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

TOP=array_magnitude_tb
LOG=sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module "$TOP" \
  --Mdir obj_dir \
  -o "$TOP"

status=0
./obj_dir/"$TOP" > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -eq 0 ] && grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
